// ==== tb/cpu_shell_input.hex ====
// words 0-15: program at byte address 0x00..0x78
// then store list: address data pairs, data ffff..ffff means the random word, all-ones address ends
0100000000000000
0120000000001234
0140000000000F0F
0228000000000000
0428000000000000
0524000000000008
0720000000000080
06A00000000000F8
07A0000000000088
06C0000000000088
07C0000000000090
0180000000002D2D
0780000000000098
0388000000000000
0880000000000060
0000000000000000
0000000000000080 00000000002E4C00
0000000000000088 FFFFFFFFFFFFFFFF
0000000000000090 FFFFFFFFFFFFFFFF
0000000000000098 0000000000002D2D
0000000000000098 0000000000001E1E
0000000000000098 0000000000000F0F
FFFFFFFFFFFFFFFF 0000000000000000

// ==== filelist.f ====
hw/cpu_shell_pkg.sv
hw/cpu_bus_if.sv
hw/instr_decode.sv
hw/alu_execute.sv
hw/result_writeback.sv
hw/cpu_core.sv
hw/bus_frame_handler.sv
hw/cpu_shell_top.sv
tb/tb_cpu_shell.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_cpu_shell
FILELIST  := filelist.f
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tb/tb_cpu_shell.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_shell;

  logic        clk = 1'b0;
  logic        rst_n;
  logic [7:0]  ui_in;
  logic [7:0]  uio_in;
  wire  [7:0]  uo_out;
  wire  [7:0]  uio_out;
  wire  [7:0]  uio_oe;

  logic [63:0] image [0:63];   // program words, then store list
  logic [63:0] mem [0:31];
  logic [4:0]  cnt;            // mirror of the frame counter
  logic [4:0]  prev_cnt;
  logic [63:0] fr_addr;
  logic [63:0] fr_wdata;
  logic        fr_write;
  logic [63:0] last_fetch;
  logic        have_fetch;
  logic [31:0] lfsr;
  logic [63:0] lfsr_word;
  logic        timed_out;
  int          frames;
  int          stores_seen;
  int          halt_reads;
  int          exp_count;
  int          checks;
  int          errs [0:5];

  cpu_shell_top i_dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .ui_in   (ui_in),
    .uo_out  (uo_out),
    .uio_in  (uio_in),
    .uio_out (uio_out),
    .uio_oe  (uio_oe)
  );

  always #4 clk = ~clk;

  // counter runs 0..17, holds at 0 while run is low
  always @(posedge clk) begin
    prev_cnt <= cnt;
    if (!rst_n) begin
      cnt <= 5'd0;
    end else if (cnt != 5'd0 || ui_in[0]) begin
      cnt <= (cnt == 5'd17) ? 5'd0 : cnt + 5'd1;
    end
  end

  function automatic logic [63:0] next_bits(input int n);
    logic        fb;
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];  // taps 32 22 2 1
      lfsr = {lfsr[30:0], fb};
      v    = {v[62:0], fb};
    end
    return v;
  endfunction

  task automatic check_val(input int id, input string name, input logic [63:0] got,
                           input logic [63:0] want);
    checks++;
    assert (got === want) else begin
      $display("** Error: %s = %h, expected %h", name, got, want);
      errs[id]++;
    end
  endtask

  function automatic int test_for_store(input int idx);
    if (idx == 0) return 2;
    if (idx <= 2) return 3;
    return 4;
  endfunction

  function automatic string test_name(input int id);
    case (id)
      0:       return "reset and first frame";
      1:       return "fetch order and direction";
      2:       return "alu results stored";
      3:       return "store load store round trip";
      4:       return "jnz loop and halt";
      default: return "run enable pause";
    endcase
  endfunction

  task automatic report_test(input int id);
    $display("test %0d %s: %s (%0d errors)", id, test_name(id),
             (errs[id] == 0) ? "ok" : "bad", errs[id]);
  endtask

  task automatic finish_frame();
    logic [63:0] word;
    logic [63:0] want;
    logic        ok;
    int          id;
    frames++;
    if (frames == 1) begin
      check_val(0, "first frame write", {63'd0, fr_write}, 64'd0);
      check_val(0, "first frame addr", fr_addr, 64'd0);
    end
    check_val(1, "uio_oe", {56'd0, uio_oe}, {56'd0, {8{fr_write}}});
    checks++;
    assert (fr_addr[63:8] == '0 && fr_addr[2:0] == '0) else begin
      $display("frame %0d uses address %h outside the memory model", frames, fr_addr);
      errs[1]++;
    end
    if (fr_write) begin
      checks++;
      assert (stores_seen < exp_count && halt_reads == 0) else begin
        $display("unexpected store to %h after the expected list or halt", fr_addr);
        errs[4]++;
      end
      if (stores_seen < exp_count) begin
        id   = test_for_store(stores_seen);
        want = image[17 + 2 * stores_seen];
        if (want === '1) want = lfsr_word;  // marker for the random word
        check_val(id, "store addr", fr_addr, image[16 + 2 * stores_seen]);
        check_val(id, "store data", fr_wdata, want);
      end
      mem[fr_addr[7:3]] = fr_wdata;
      stores_seen++;
    end else begin
      check_val(1, "uio_out on read", fr_wdata, 64'd0);
      if (fr_addr < 64'h80) begin
        if (have_fetch) begin
          word = mem[last_fetch[7:3]];
          case (word[63:56])
            8'h00:   ok = fr_addr == last_fetch;
            8'h08:   ok = fr_addr == last_fetch + 8 ||
                          fr_addr == {{16{word[47]}}, word[47:0]};
            default: ok = fr_addr == last_fetch + 8;
          endcase
          checks++;
          assert (ok) else begin
            $display("fetch at %h does not follow the fetch at %h", fr_addr, last_fetch);
            errs[1]++;
          end
        end
        if (mem[fr_addr[7:3]][63:56] == 8'h00) halt_reads++;
        have_fetch = 1'b1;
        last_fetch = fr_addr;
      end
    end
  endtask

  // rebuild each frame from the pins and answer reads
  always @(negedge clk) begin
    int b;
    if (rst_n) begin
      if (prev_cnt >= 5'd1 && prev_cnt <= 5'd8) begin
        b = int'(prev_cnt) - 1;
        fr_addr[8*b +: 8]  = uo_out;
        fr_wdata[8*b +: 8] = uio_out;
      end else if (prev_cnt == 5'd9) begin
        fr_write = uo_out[0];
        check_val(1, "uo_out[7:1] at flag", {57'd0, uo_out[7:1]}, 64'd0);
        finish_frame();
      end
      if (cnt >= 5'd10 && cnt <= 5'd17 && !fr_write) begin
        b = int'(cnt) - 10;
        uio_in = 8'(mem[fr_addr[7:3]] >> (8 * b));
      end else begin
        uio_in = 8'h00;
      end
    end
  end

  task automatic wait_stores(input int n, input int limit);
    int t;
    t = 0;
    while (stores_seen < n && t < limit) begin
      @(negedge clk);
      t++;
    end
    if (stores_seen < n) begin
      $display("timeout: saw %0d of %0d stores", stores_seen, n);
      timed_out = 1'b1;
    end
  endtask

  task automatic wait_halt(input int limit);
    int t;
    t = 0;
    while (halt_reads < 4 && t < limit) begin
      @(negedge clk);
      t++;
    end
    if (halt_reads < 4) begin
      $display("timeout: core never settled on the halt address");
      timed_out = 1'b1;
    end
  endtask

  task automatic pause_run();
    logic [63:0] stretch;
    int          t;
    ui_in = 8'h00;
    t     = 0;
    while (!(cnt == 5'd0 && prev_cnt == 5'd0) && t < 40) begin
      @(negedge clk);
      t++;
    end
    if (t >= 40) begin
      $display("timeout: frame counter did not stop at step 0");
      timed_out = 1'b1;
    end
    stretch = next_bits(5);
    for (int i = 0; i < 12 + int'(stretch); i++) begin
      @(negedge clk);
      check_val(5, "uo_out while paused", {56'd0, uo_out}, 64'd0);
      check_val(5, "uio_out while paused", {56'd0, uio_out}, 64'd0);
      check_val(5, "uio_oe while paused", {56'd0, uio_oe}, {56'd0, {8{fr_write}}});
    end
    ui_in = 8'h01;
  endtask

  initial begin
    int total;
    rst_n = 1'b0;
    ui_in = 8'h01;   // run enable
    uio_in = 8'h00;
    cnt = 5'd0;
    prev_cnt = 5'd0;
    fr_addr = '0;
    fr_wdata = '0;
    fr_write = 1'b0;
    have_fetch = 1'b0;
    last_fetch = '0;
    timed_out = 1'b0;
    frames = 0;
    stores_seen = 0;
    halt_reads = 0;
    checks = 0;
    for (int i = 0; i < 6; i++) errs[i] = 0;
    lfsr = 32'h8e5b;
    for (int i = 0; i < 64; i++) image[i] = '1;
    $readmemh("tb/cpu_shell_input.hex", image);
    for (int i = 0; i < 32; i++) begin
      mem[i] = (i < 16) ? image[i] : {32'(i * 8), ~32'(i * 8)};
    end
    lfsr_word = next_bits(64);
    mem[31] = lfsr_word;  // source of the round trip
    exp_count = 0;
    while (exp_count < 20 && image[16 + 2 * exp_count] !== '1) exp_count++;

    repeat (5) begin
      @(negedge clk);
      check_val(0, "uo_out in reset", {56'd0, uo_out}, 64'd0);
      check_val(0, "uio_out in reset", {56'd0, uio_out}, 64'd0);
      check_val(0, "uio_oe in reset", {56'd0, uio_oe}, 64'd0);
    end
    rst_n = 1'b1;
    @(negedge clk);
    check_val(0, "uo_out after reset", {56'd0, uo_out}, 64'd0);
    check_val(0, "uio_out after reset", {56'd0, uio_out}, 64'd0);
    check_val(0, "uio_oe after reset", {56'd0, uio_oe}, 64'd0);

    wait_stores(1, 2000);
    report_test(0);
    if (!timed_out) pause_run();
    if (!timed_out) wait_stores(2, 2000);
    report_test(5);
    if (!timed_out) wait_stores(exp_count, 4000);
    if (!timed_out) wait_halt(400);
    check_val(4, "stores seen", 64'(stores_seen), 64'(exp_count));
    check_val(4, "halt address", last_fetch, 64'h78);
    for (int i = 1; i < 5; i++) report_test(i);

    total = 0;
    for (int i = 0; i < 6; i++) total += errs[i];
    $display("checks %0d, errors %0d, timeout %0d", checks, total, timed_out);
    if (total == 0 && !timed_out) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/cpu_shell_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_shell_top (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [7:0] ui_in,    // bit 0 is run enable
  output logic [7:0] uo_out,
  input  logic [7:0] uio_in,
  output logic [7:0] uio_out,
  output logic [7:0] uio_oe
);

  cpu_bus_if bus ();

  cpu_core i_core (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (bus.core)
  );

  bus_frame_handler i_handler (
    .clk     (clk),
    .rst_n   (rst_n),
    .run     (ui_in[0]),
    .bus     (bus.handler),
    .uo_out  (uo_out),
    .uio_out (uio_out),
    .uio_oe  (uio_oe),
    .uio_in  (uio_in)
  );

endmodule

`default_nettype wire

// ==== hw/bus_frame_handler.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_frame_handler (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       run,
  cpu_bus_if.handler bus,
  output logic [7:0] uo_out,
  output logic [7:0] uio_out,
  output logic [7:0] uio_oe,
  input  logic [7:0] uio_in
);
  import cpu_shell_pkg::*;

  frame_step_t     count;
  logic            primed;      // set once the first frame has completed
  logic [2:0]      addr_byte;
  logic [2:0]      data_byte;
  logic            in_addr;
  logic            in_data;
  logic            last_step;
  logic [xlen-1:0] rdata_q;

  assign addr_byte = 3'(count - step_addr_first);
  assign data_byte = 3'(count - step_data_first);
  assign in_addr   = (count >= step_addr_first) && (count < step_flag);
  assign in_data   = count >= step_data_first;
  assign last_step = count == frame_step_t'(frame_len - 1);

  assign bus.step  = run && primed && (count == step_core);
  assign bus.rdata = rdata_q;
  assign uio_oe    = {8{bus.write}};  // pins drive only on write frames

  // step 0 waits for run, every other step just advances
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count  <= step_core;
      primed <= 1'b0;
    end else if (count != step_core || run) begin
      if (last_step) begin
        count  <= step_core;
        primed <= 1'b1;
      end else begin
        count <= count + 1'b1;
      end
    end
  end

  // pins show what the previous step asked for
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      uo_out  <= 8'h00;
      uio_out <= 8'h00;
    end else if (in_addr) begin
      uo_out  <= bus.addr[8*addr_byte +: 8];             // lsb first
      uio_out <= bus.write ? bus.wdata[8*addr_byte +: 8] : 8'h00;
    end else if (count == step_flag) begin
      uo_out  <= {7'b0000000, bus.write};
      uio_out <= 8'h00;
    end else begin
      uo_out  <= 8'h00;
      uio_out <= 8'h00;
    end
  end

  // read data comes back one byte per step
  always_ff @(posedge clk) begin
    if (in_data) begin
      rdata_q[8*data_byte +: 8] <= uio_in;
    end
  end

  a_count_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    count < frame_step_t'(frame_len)
  );

endmodule

`default_nettype wire

// ==== hw/cpu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
  input  logic    clk,
  input  logic    rst_n,
  cpu_bus_if.core bus
);
  import cpu_shell_pkg::*;

  logic            mem_phase;   // 0 fetch, 1 load/store access
  logic [xlen-1:0] ir;
  logic [xlen-1:0] instr;
  decoded_instr_t  dec;
  logic [xlen-1:0] rd_val;
  logic [xlen-1:0] rs_val;
  logic [xlen-1:0] pc;
  logic [xlen-1:0] alu_result;
  logic [xlen-1:0] mem_addr;
  logic [xlen-1:0] next_pc;
  logic [xlen-1:0] store_data;
  logic            is_mem;
  logic            retire;

  // fetch decodes the word arriving on the bus, memory phase the held one
  assign instr = mem_phase ? ir : bus.rdata;

  instr_decode i_decode (
    .instr (instr),
    .dec   (dec)
  );

  alu_execute i_execute (
    .dec        (dec),
    .rd_val     (rd_val),
    .rs_val     (rs_val),
    .pc         (pc),
    .alu_result (alu_result),
    .mem_addr   (mem_addr),
    .next_pc    (next_pc)
  );

  result_writeback i_result (
    .clk        (clk),
    .rst_n      (rst_n),
    .retire     (retire),
    .dec        (dec),
    .alu_result (alu_result),
    .load_data  (bus.rdata),
    .next_pc    (next_pc),
    .rd_val     (rd_val),
    .rs_val     (rs_val),
    .pc         (pc),
    .store_data (store_data)
  );

  assign is_mem = dec.is_load || dec.is_store;
  assign retire = bus.step && (mem_phase || !is_mem);

  assign bus.addr  = mem_phase ? mem_addr : pc;
  assign bus.write = mem_phase && dec.is_store;
  assign bus.wdata = mem_phase ? store_data : '0;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mem_phase <= 1'b0;
    end else if (bus.step) begin
      mem_phase <= !mem_phase && is_mem;
    end
  end

  always_ff @(posedge clk) begin
    if (bus.step && !mem_phase) begin
      ir <= bus.rdata;
    end
  end

  // every fetched word must decode to a known opcode
  a_fetch_legal: assert property (
    @(posedge clk) disable iff (!rst_n)
    (bus.step && !mem_phase) |-> !dec.illegal
  );

endmodule

`default_nettype wire

// ==== hw/result_writeback.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_writeback (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           retire,
  input  cpu_shell_pkg::decoded_instr_t  dec,
  input  logic [cpu_shell_pkg::xlen-1:0] alu_result,
  input  logic [cpu_shell_pkg::xlen-1:0] load_data,
  input  logic [cpu_shell_pkg::xlen-1:0] next_pc,
  output logic [cpu_shell_pkg::xlen-1:0] rd_val,
  output logic [cpu_shell_pkg::xlen-1:0] rs_val,
  output logic [cpu_shell_pkg::xlen-1:0] pc,
  output logic [cpu_shell_pkg::xlen-1:0] store_data
);
  import cpu_shell_pkg::*;

  logic [xlen-1:0] regs [reg_count];
  logic [xlen-1:0] wb_data;

  // combinational read ports
  assign rd_val = regs[dec.rd];
  assign rs_val = regs[dec.rs];

  // only a store puts rd on the bus
  assign store_data = dec.is_store ? regs[dec.rd] : '0;

  assign wb_data = dec.is_load ? load_data : alu_result;

  always_ff @(posedge clk) begin
    if (retire && dec.writes_rd) begin
      regs[dec.rd] <= wb_data;  // r0 is writable too
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (retire) begin
      pc <= next_pc;
    end
  end

endmodule

`default_nettype wire

// ==== hw/alu_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_execute (
  input  cpu_shell_pkg::decoded_instr_t  dec,
  input  logic [cpu_shell_pkg::xlen-1:0] rd_val,
  input  logic [cpu_shell_pkg::xlen-1:0] rs_val,
  input  logic [cpu_shell_pkg::xlen-1:0] pc,
  output logic [cpu_shell_pkg::xlen-1:0] alu_result,
  output logic [cpu_shell_pkg::xlen-1:0] mem_addr,
  output logic [cpu_shell_pkg::xlen-1:0] next_pc
);
  import cpu_shell_pkg::*;

  logic [5:0] shamt;

  assign shamt = dec.imm[5:0];  // shift amount modulo 64

  // two-operand ops accumulate into rd
  always_comb begin
    case (dec.op)
      op_li:   alu_result = dec.imm;
      op_add:  alu_result = rd_val + rs_val;
      op_sub:  alu_result = rd_val - rs_val;
      op_xor:  alu_result = rd_val ^ rs_val;
      op_shl:  alu_result = rs_val << shamt;
      default: alu_result = '0;
    endcase
  end

  assign mem_addr = rs_val + dec.imm;  // base plus offset

  always_comb begin
    if (dec.illegal || dec.op == op_halt) begin
      next_pc = pc;  // spin on the same word
    end else if (dec.is_branch && rd_val != '0) begin
      next_pc = dec.imm;
    end else begin
      next_pc = pc + xlen'(instr_bytes);
    end
  end

endmodule

`default_nettype wire

// ==== hw/instr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
  input  logic [cpu_shell_pkg::xlen-1:0] instr,
  output cpu_shell_pkg::decoded_instr_t  dec
);
  import cpu_shell_pkg::*;

  logic [7:0] op_raw;

  assign op_raw = instr[63:56];

  always_comb begin
    dec           = '0;
    dec.op        = opcode_t'(op_raw);
    dec.rd        = instr[55:53];
    dec.rs        = instr[52:50];
    dec.imm       = {{(xlen - 48){instr[47]}}, instr[47:0]};  // sign-extend
    case (op_raw)
      op_halt: begin
        dec.writes_rd = 1'b0;
      end
      op_li, op_add, op_sub, op_xor, op_shl: begin
        dec.writes_rd = 1'b1;
      end
      op_ld: begin
        dec.is_load   = 1'b1;
        dec.writes_rd = 1'b1;
      end
      op_st: begin
        dec.is_store  = 1'b1;
      end
      op_jnz: begin
        dec.is_branch = 1'b1;
      end
      default: begin
        dec.illegal   = 1'b1;  // core stalls on it like halt
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/cpu_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface cpu_bus_if;
  import cpu_shell_pkg::*;

  logic [xlen-1:0] addr;
  logic [xlen-1:0] wdata;
  logic            write;
  logic [xlen-1:0] rdata;
  logic            step;    // one cycle, transaction done

  modport core (
    output addr, wdata, write,
    input  rdata, step
  );

  modport handler (
    input  addr, wdata, write,
    output rdata, step
  );

endinterface

`default_nettype wire

// ==== hw/cpu_shell_pkg.sv ====
`default_nettype none

package cpu_shell_pkg;

  localparam int xlen        = 64;
  localparam int reg_count   = 8;
  localparam int reg_idx_w   = 3;
  localparam int frame_len   = 18;
  localparam int instr_bytes = xlen / 8;  // pc stride

  // opcode lives in instr[63:56]
  typedef enum logic [7:0] {
    op_halt = 8'h00,
    op_li   = 8'h01,
    op_add  = 8'h02,
    op_sub  = 8'h03,
    op_xor  = 8'h04,
    op_shl  = 8'h05,
    op_ld   = 8'h06,
    op_st   = 8'h07,
    op_jnz  = 8'h08
  } opcode_t;

  typedef struct packed {
    opcode_t                op;
    logic [reg_idx_w-1:0]   rd;
    logic [reg_idx_w-1:0]   rs;
    logic [xlen-1:0]        imm;        // already sign-extended
    logic                   is_load;
    logic                   is_store;
    logic                   is_branch;
    logic                   writes_rd;
    logic                   illegal;
  } decoded_instr_t;

  // frame step index and the steps that start each part of a frame
  typedef logic [4:0] frame_step_t;

  localparam frame_step_t step_core       = 5'd0;
  localparam frame_step_t step_addr_first = 5'd1;
  localparam frame_step_t step_flag       = 5'd9;
  localparam frame_step_t step_data_first = 5'd10;

endpackage

`default_nettype wire
